/* sim.f */
cpu_pkg.sv
alu.sv
register_file.sv
control_unit.sv
forwarding_unit.sv
hazard_unit.sv
datapath.sv
tb_datapath.sv

/* Bender.yml */
package:
  name: pipeline_cpu

sources:
  - cpu_pkg.sv
  - alu.sv
  - register_file.sv
  - control_unit.sv
  - forwarding_unit.sv
  - hazard_unit.sv
  - datapath.sv
  - target: test
    files:
      - tb_datapath.sv

/* tb_datapath.sv */
`timescale 1ns/100ps

module tb_datapath;
  import cpu_pkg::*;

  // 60 instructions, x4 for slow data hits, x8 margin, rounded up.
  localparam int    TIMEOUT_CYCLES = 2000;
  localparam int    N_STORES       = 16;
  localparam word_t STORE_BASE     = 32'h0000_0200;
  localparam word_t POISON_ADDR    = 32'h0000_0ff0;
  localparam word_t PRELOAD_ADDR   = 32'h0000_0400;
  localparam word_t PRELOAD_WORD   = 32'h1234_5678;
  localparam logic [31:0] LFSR_SEED = 32'hf3b5c78b;

  logic  CLK = 1'b0;
  logic  nRST;
  logic  ihit = 1'b1;
  logic  dhit = 1'b0;
  word_t dmemload = '0;
  word_t imemaddr, imemload, dmemaddr, dmemstore;
  logic  imemREN, dmemREN, dmemWEN, halt;

  word_t       imem [0:255];
  word_t       dmem [word_t];
  word_t       exp_addr [N_STORES];
  word_t       exp_data [N_STORES];
  logic        written [N_STORES] = '{default: 1'b0};
  int          n_filled = 0;
  int          stores_seen = 0;
  int          prog_len = 0;
  int          wait_cnt = 0;
  int          hit_delay = 0;
  int          cycles = 0;
  logic [31:0] lfsr = LFSR_SEED;
  word_t       jal_link;

  datapath dut_i (
    .CLK(CLK), .nRST(nRST),
    .imemaddr(imemaddr), .imemREN(imemREN), .imemload(imemload), .ihit(ihit),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .dmemload(dmemload), .dhit(dhit), .halt(halt)
  );

  always #2 CLK = ~CLK;

  // instruction memory answers at once.
  assign imemload = imem[imemaddr[9:2]];

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // two bits give a wait of 0 to 3 cycles.
  task automatic draw_delay();
    int d;
    d = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_step(lfsr);
      d = (d << 1) | int'(lfsr[0]);
    end
    hit_delay = d;
  endtask

  function automatic word_t fill_word(word_t a);
    return ~a ^ 32'h1357_9bdf;
  endfunction

  function automatic word_t read_word(word_t a);
    return dmem.exists(a) ? dmem[a] : fill_word(a);
  endfunction

  function automatic word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t zext16(logic [15:0] v);
    return {16'h0000, v};
  endfunction

  function automatic instr_t enc_r(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd);
    instr_t w;
    w.r.opcode = RTYPE;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.shamt  = '0;
    w.r.funct  = f;
    return w;
  endfunction

  function automatic instr_t enc_i(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
    instr_t w;
    w.i.opcode = op;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm16  = imm;
    return w;
  endfunction

  function automatic instr_t enc_j(opcode_t op, int target);
    instr_t w;
    w.j.opcode = op;
    w.j.addr26 = 26'(target);
    return w;
  endfunction

  task automatic put(instr_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // a store that only runs if a taken transfer fails to skip it.
  task automatic put_poison();
    put(enc_i(SW, 5'd0, 5'd2, POISON_ADDR[15:0]));
  endtask

  task automatic load_program();
    // unused words are no-ops tagged with their index.
    for (int i = 0; i < 256; i++) begin
      imem[i] = word_t'(i) << 6;
    end
    put(enc_i(ORI, 5'd0, 5'd1, STORE_BASE[15:0]));
    put(enc_i(ADDIU, 5'd0, 5'd2, 16'h0015));
    put(enc_i(ADDIU, 5'd0, 5'd3, 16'hfff9));
    put(enc_r(ADDU, 5'd2, 5'd3, 5'd4));
    put(enc_i(SW, 5'd1, 5'd4, 16'd0));
    put(enc_r(SUBU, 5'd2, 5'd3, 5'd5));
    put(enc_i(SW, 5'd1, 5'd5, 16'd4));
    put(enc_r(AND, 5'd2, 5'd3, 5'd6));
    put(enc_r(OR, 5'd2, 5'd3, 5'd7));
    put(enc_i(SW, 5'd1, 5'd6, 16'd8));
    put(enc_i(SW, 5'd1, 5'd7, 16'd12));
    put(enc_r(SLT, 5'd3, 5'd2, 5'd8));
    put(enc_r(SLT, 5'd2, 5'd3, 5'd9));
    put(enc_i(SW, 5'd1, 5'd8, 16'd16));
    put(enc_i(SW, 5'd1, 5'd9, 16'd20));
    put(enc_i(ORI, 5'd0, 5'd10, 16'h8001));
    put(enc_i(SW, 5'd1, 5'd10, 16'd24));
    put(enc_i(LUI, 5'd0, 5'd11, 16'hbeef));
    put(enc_i(ORI, 5'd11, 5'd11, 16'h00f0));
    put(enc_i(SW, 5'd1, 5'd11, 16'd28));
    put(enc_i(ADDIU, 5'd10, 5'd12, 16'h8000));
    put(enc_i(SW, 5'd1, 5'd12, 16'd32));
    // load followed at once by its user.
    put(enc_i(LW, 5'd1, 5'd13, 16'(PRELOAD_ADDR - STORE_BASE)));
    put(enc_i(ADDIU, 5'd13, 5'd14, 16'h0100));
    put(enc_i(SW, 5'd1, 5'd14, 16'd36));
    put(enc_i(LW, 5'd1, 5'd15, 16'd4));
    put(enc_i(SW, 5'd1, 5'd15, 16'd40));
    // word 27, taken beq to 30.
    put(enc_i(BEQ, 5'd2, 5'd2, 16'd2));
    put_poison();
    put_poison();
    put(enc_i(BNE, 5'd2, 5'd3, 16'd2));
    put_poison();
    put_poison();
    // word 33, both of these fall through.
    put(enc_i(BEQ, 5'd2, 5'd3, 16'd1));
    put(enc_i(SW, 5'd1, 5'd2, 16'd44));
    put(enc_i(BNE, 5'd2, 5'd2, 16'd1));
    put(enc_i(SW, 5'd1, 5'd3, 16'd48));
    put(enc_j(J, 40));
    put_poison();
    put_poison();
    // word 40, call the routine at 46.
    jal_link = word_t'(prog_len) * 4 + 4;
    put(enc_j(JAL, 46));
    put(enc_i(SW, 5'd1, 5'd31, 16'd52));
    put(enc_j(J, 50));
    put_poison();
    put_poison();
    put_poison();
    put(enc_i(ADDIU, 5'd0, 5'd16, 16'h0055));
    put(enc_i(SW, 5'd1, 5'd16, 16'd56));
    put(enc_r(JR, 5'd31, 5'd0, 5'd0));
    put_poison();
    // word 50, tail.
    put(enc_i(ADDIU, 5'd0, 5'd17, 16'h0077));
    put(enc_i(SW, 5'd1, 5'd17, 16'd60));
    put(enc_j(HALT, 0));
  endtask

  task automatic expect_store(word_t offset, word_t data);
    exp_addr[n_filled] = STORE_BASE + offset;
    exp_data[n_filled] = data;
    n_filled++;
  endtask

  task automatic build_expected();
    word_t r2, r3, r10, r11;
    r2  = sext16(16'h0015);
    r3  = sext16(16'hfff9);
    r10 = zext16(16'h8001);
    r11 = {16'hbeef, 16'h0000} | zext16(16'h00f0);
    expect_store(0, r2 + r3);
    expect_store(4, r2 - r3);
    expect_store(8, r2 & r3);
    expect_store(12, r2 | r3);
    expect_store(16, {31'b0, $signed(r3) < $signed(r2)});
    expect_store(20, {31'b0, $signed(r2) < $signed(r3)});
    expect_store(24, r10);
    expect_store(28, r11);
    expect_store(32, r10 + sext16(16'h8000));
    expect_store(36, PRELOAD_WORD + sext16(16'h0100));
    expect_store(40, r2 - r3);
    expect_store(44, r2);
    expect_store(48, r3);
    expect_store(52, jal_link);
    expect_store(56, zext16(16'h0055));
    expect_store(60, zext16(16'h0077));
  endtask

  function automatic int table_index(word_t addr);
    int idx;
    idx = -1;
    for (int k = 0; k < N_STORES; k++) begin
      if (exp_addr[k] == addr) begin
        idx = k;
      end
    end
    return idx;
  endfunction

  function automatic word_t expected_at(word_t addr);
    int idx;
    idx = table_index(addr);
    return (idx >= 0) ? exp_data[idx] : '0;
  endfunction

  function automatic int count_missing();
    int n;
    n = 0;
    for (int k = 0; k < N_STORES; k++) begin
      if (!written[k]) begin
        n++;
      end
    end
    return n;
  endfunction

  // data memory, one hit per request after a random wait.
  always @(posedge CLK) begin : data_memory
    if (!nRST) begin
      dmem[PRELOAD_ADDR] = PRELOAD_WORD;
      dhit     <= 1'b0;
      wait_cnt <= 0;
    end else if (dhit) begin
      if (dmemWEN) begin
        dmem[dmemaddr] = dmemstore;
      end
      dhit     <= 1'b0;
      wait_cnt <= 0;
      draw_delay();
    end else if (dmemREN || dmemWEN) begin
      if (wait_cnt >= hit_delay) begin
        dhit     <= 1'b1;
        dmemload <= read_word(dmemaddr);
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end
  end

  always @(posedge CLK) begin : record_stores
    int idx;
    if (nRST && dmemWEN && dhit) begin
      idx = table_index(dmemaddr);
      if (idx >= 0) begin
        assert (!written[idx])
          else stop_on_error($sformatf("address %h was stored to a second time", dmemaddr));
        written[idx] <= 1'b1;
        stores_seen  <= stores_seen + 1;
      end
    end
  end

  always @(posedge CLK) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_on_error("timeout, halt never rose");
    end
  end

  imem_always_read: assert property (@(posedge CLK) disable iff (!nRST)
    imemREN == 1'b1)
    else stop_on_error($sformatf("[FAIL] imemREN: got %h, expected %h",
      $sampled(imemREN), 1'b1));

  store_address_known: assert property (@(posedge CLK) disable iff (!nRST)
    (dmemWEN && dhit) |-> (table_index(dmemaddr) >= 0))
    else stop_on_error($sformatf("store to unexpected address %h", $sampled(dmemaddr)));

  store_data_matches: assert property (@(posedge CLK) disable iff (!nRST)
    (dmemWEN && dhit && table_index(dmemaddr) >= 0) |-> (dmemstore == expected_at(dmemaddr)))
    else stop_on_error($sformatf("[FAIL] dmemstore at dmemaddr %h: got %h, expected %h",
      $sampled(dmemaddr), $sampled(dmemstore), expected_at($sampled(dmemaddr))));

  skipped_store_blocked: assert property (@(posedge CLK) disable iff (!nRST)
    dmemWEN |-> (dmemaddr != POISON_ADDR))
    else stop_on_error("a store from a skipped slot reached data memory");

  request_held: assert property (@(posedge CLK) disable iff (!nRST)
    ((dmemREN || dmemWEN) && !dhit) |=>
      ($stable(dmemaddr) && $stable(dmemstore) && $stable(dmemREN) && $stable(dmemWEN)))
    else stop_on_error("data request changed while waiting for dhit");

  halt_after_stores: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(halt) |-> (stores_seen == N_STORES))
    else stop_on_error($sformatf("[FAIL] stores_seen when halt rose: got %h, expected %h",
      $sampled(stores_seen), N_STORES));

  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else stop_on_error("halt dropped after it was raised");

  quiet_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !(dmemREN || dmemWEN))
    else stop_on_error("data request seen after halt");

  initial begin
    nRST = 1'b0;
    load_program();
    build_expected();
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    wait (halt === 1'b1);
    // a few more cycles so the sticky checks get to run.
    repeat (4) @(posedge CLK);
    if (count_missing() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d expected stores never happened", count_missing()));
    end
  end

endmodule

/* datapath.sv */
`timescale 1ns/100ps

module datapath (
  input  logic           CLK,
  input  logic           nRST,
  output cpu_pkg::word_t imemaddr,
  output logic           imemREN,
  input  cpu_pkg::word_t imemload,
  input  logic           ihit,
  output logic           dmemREN,
  output logic           dmemWEN,
  output cpu_pkg::word_t dmemaddr,
  output cpu_pkg::word_t dmemstore,
  input  cpu_pkg::word_t dmemload,
  input  logic           dhit,
  output logic           halt
);
  import cpu_pkg::*;

  logic     pcen, if_id_en, id_ex_en, ex_mem_en, mem_wb_en;
  logic     if_id_flush, id_ex_flush, ex_mem_flush;
  word_t    pc, pc4, npc;
  instr_t   if_id_instr;
  word_t    if_id_pc4;
  aluop_t   cu_aluop;
  alusrc_t  cu_alusrc;
  regsrc_t  cu_regsrc;
  regdst_t  cu_regdst;
  pcsrc_t   cu_pcsrc;
  logic     cu_extsel, cu_regWEN, cu_dREN, cu_dWEN, cu_halt;
  word_t    imm32, rdat1, rdat2;
  logic     halt_seen;
  logic     id_ex_regWEN, id_ex_dREN, id_ex_dWEN, id_ex_halt;
  pcsrc_t   id_ex_pcsrc;
  aluop_t   id_ex_aluop;
  alusrc_t  id_ex_alusrc;
  regsrc_t  id_ex_regsrc;
  regdst_t  id_ex_regdst;
  word_t    id_ex_rdat1, id_ex_rdat2, id_ex_imm32, id_ex_pc4;
  instr_t   id_ex_instr;
  fwd_t     forward_a, forward_b;
  word_t    opnd_a, opnd_b, alu_out, ex_target, ex_result;
  logic     alu_zero, ex_regWEN;
  regbits_t ex_rd;
  logic     ex_mem_regWEN, ex_mem_dREN, ex_mem_dWEN, ex_mem_halt, ex_mem_zero;
  pcsrc_t   ex_mem_pcsrc;
  regsrc_t  ex_mem_regsrc;
  regbits_t ex_mem_rd;
  word_t    ex_mem_result, ex_mem_store, ex_mem_target;
  logic     mem_wb_regWEN, mem_wb_halt;
  regsrc_t  mem_wb_regsrc;
  regbits_t mem_wb_rd;
  word_t    mem_wb_result, mem_wb_dload, wb_wdat;

  // fetch.
  assign pc4      = pc + 32'd4;
  assign imemaddr = pc;
  assign imemREN  = 1'b1;
  // a mem-stage flush only happens for a taken transfer.
  assign npc = ex_mem_flush ? ex_mem_target : pc4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (pcen) begin
      pc <= npc;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      if_id_instr <= '0;
    end else if (if_id_en) begin
      if_id_instr <= if_id_flush ? instr_t'('0) : instr_t'(imemload);
    end
  end

  always_ff @(posedge CLK) begin
    if (if_id_en) begin
      if_id_pc4 <= pc4;
    end
  end

  // decode.
  control_unit cu (
    .opcode(if_id_instr.r.opcode), .funct(if_id_instr.r.funct),
    .aluop(cu_aluop), .alusrc(cu_alusrc), .regsrc(cu_regsrc), .regdst(cu_regdst),
    .pcsrc(cu_pcsrc), .extsel(cu_extsel), .regWEN(cu_regWEN), .dREN(cu_dREN),
    .dWEN(cu_dWEN), .halt_op(cu_halt)
  );

  register_file rf (
    .CLK(CLK), .nRST(nRST), .WEN(mem_wb_regWEN), .wsel(mem_wb_rd),
    .rsel1(if_id_instr.r.rs), .rsel2(if_id_instr.r.rt), .wdat(wb_wdat),
    .rdat1(rdat1), .rdat2(rdat2)
  );

  assign imm32 = cu_extsel ? {{16{if_id_instr.i.imm16[15]}}, if_id_instr.i.imm16}
                           : {16'h0000, if_id_instr.i.imm16};

  // fetch stays stopped while a halt is anywhere past fetch.
  assign halt_seen = cu_halt | id_ex_halt | ex_mem_halt | mem_wb_halt | halt;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex_regWEN <= 1'b0;
      id_ex_dREN   <= 1'b0;
      id_ex_dWEN   <= 1'b0;
      id_ex_halt   <= 1'b0;
      id_ex_pcsrc  <= PCSRC_NEXT;
    end else if (id_ex_en) begin
      id_ex_regWEN <= cu_regWEN & ~id_ex_flush;
      id_ex_dREN   <= cu_dREN & ~id_ex_flush;
      id_ex_dWEN   <= cu_dWEN & ~id_ex_flush;
      id_ex_halt   <= cu_halt & ~id_ex_flush;
      id_ex_pcsrc  <= id_ex_flush ? PCSRC_NEXT : cu_pcsrc;
    end
  end

  always_ff @(posedge CLK) begin
    if (id_ex_en) begin
      id_ex_aluop  <= cu_aluop;
      id_ex_alusrc <= cu_alusrc;
      id_ex_regsrc <= cu_regsrc;
      id_ex_regdst <= cu_regdst;
      id_ex_rdat1  <= rdat1;
      id_ex_rdat2  <= rdat2;
      id_ex_imm32  <= imm32;
      id_ex_instr  <= if_id_instr;
      id_ex_pc4    <= if_id_pc4;
    end
  end

  // execute.
  forwarding_unit fu (
    .ex_mem_regWEN(ex_mem_regWEN), .ex_mem_rd(ex_mem_rd),
    .mem_wb_regWEN(mem_wb_regWEN), .mem_wb_rd(mem_wb_rd),
    .rs(id_ex_instr.r.rs), .rt(id_ex_instr.r.rt),
    .forward_a(forward_a), .forward_b(forward_b)
  );

  assign opnd_a = (forward_a == FWD_EX_MEM) ? ex_mem_result :
                  (forward_a == FWD_MEM_WB) ? wb_wdat : id_ex_rdat1;
  assign opnd_b = (forward_b == FWD_EX_MEM) ? ex_mem_result :
                  (forward_b == FWD_MEM_WB) ? wb_wdat : id_ex_rdat2;

  alu alu0 (
    .aluop(id_ex_aluop), .port_a(opnd_a),
    .port_b((id_ex_alusrc == ALUSRC_IMM) ? id_ex_imm32 : opnd_b),
    .port_o(alu_out), .zero(alu_zero)
  );

  always_comb begin
    case (id_ex_pcsrc)
      PCSRC_REG: ex_target = opnd_a;
      PCSRC_JMP: ex_target = {id_ex_pc4[31:28], id_ex_instr.j.addr26, 2'b00};
      default:   ex_target = id_ex_pc4 + (id_ex_imm32 << 2);
    endcase
    case (id_ex_regsrc)
      REGSRC_LUI: ex_result = {id_ex_instr.i.imm16, 16'h0000};
      REGSRC_PC4: ex_result = id_ex_pc4;
      default:    ex_result = alu_out;
    endcase
    case (id_ex_regdst)
      REGDST_RD: ex_rd = id_ex_instr.r.rd;
      REGDST_RT: ex_rd = id_ex_instr.r.rt;
      REGDST_RA: ex_rd = REG_RA;
      default:   ex_rd = '0;
    endcase
  end

  // writes to r0 are dropped here.
  assign ex_regWEN = id_ex_regWEN && (ex_rd != '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_mem_regWEN <= 1'b0;
      ex_mem_dREN   <= 1'b0;
      ex_mem_dWEN   <= 1'b0;
      ex_mem_halt   <= 1'b0;
      ex_mem_pcsrc  <= PCSRC_NEXT;
    end else if (ex_mem_en) begin
      ex_mem_regWEN <= ex_regWEN & ~ex_mem_flush;
      ex_mem_dREN   <= id_ex_dREN & ~ex_mem_flush;
      ex_mem_dWEN   <= id_ex_dWEN & ~ex_mem_flush;
      ex_mem_halt   <= id_ex_halt & ~ex_mem_flush;
      ex_mem_pcsrc  <= ex_mem_flush ? PCSRC_NEXT : id_ex_pcsrc;
    end
  end

  always_ff @(posedge CLK) begin
    if (ex_mem_en) begin
      ex_mem_zero   <= alu_zero;
      ex_mem_regsrc <= id_ex_regsrc;
      ex_mem_rd     <= ex_rd;
      ex_mem_result <= ex_result;
      ex_mem_store  <= opnd_b;
      ex_mem_target <= ex_target;
    end
  end

  // memory.
  assign dmemREN   = ex_mem_dREN;
  assign dmemWEN   = ex_mem_dWEN;
  assign dmemaddr  = ex_mem_result;
  assign dmemstore = ex_mem_store;

  hazard_unit hu (
    .ex_dREN(id_ex_dREN), .ex_rd(ex_rd), .id_rs(if_id_instr.r.rs),
    .id_rt(if_id_instr.r.rt), .mem_pcsrc(ex_mem_pcsrc), .mem_zero(ex_mem_zero),
    .id_halt(halt_seen), .ihit(ihit), .dhit(dhit),
    .mem_dreq(ex_mem_dREN | ex_mem_dWEN), .pcen(pcen), .if_id_en(if_id_en),
    .id_ex_en(id_ex_en), .ex_mem_en(ex_mem_en), .mem_wb_en(mem_wb_en),
    .if_id_flush(if_id_flush), .id_ex_flush(id_ex_flush), .ex_mem_flush(ex_mem_flush)
  );

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_wb_regWEN <= 1'b0;
      mem_wb_halt   <= 1'b0;
    end else if (mem_wb_en) begin
      mem_wb_regWEN <= ex_mem_regWEN;
      mem_wb_halt   <= ex_mem_halt;
    end
  end

  always_ff @(posedge CLK) begin
    if (mem_wb_en) begin
      mem_wb_regsrc <= ex_mem_regsrc;
      mem_wb_rd     <= ex_mem_rd;
      mem_wb_result <= ex_mem_result;
      mem_wb_dload  <= dmemload;
    end
  end

  // write back.
  assign wb_wdat = (mem_wb_regsrc == REGSRC_MEM) ? mem_wb_dload : mem_wb_result;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else begin
      halt <= halt | mem_wb_halt;
    end
  end

  dmem_one_hot: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmemREN && dmemWEN));

endmodule

/* hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
  input  logic              ex_dREN,
  input  cpu_pkg::regbits_t ex_rd,
  input  cpu_pkg::regbits_t id_rs,
  input  cpu_pkg::regbits_t id_rt,
  input  cpu_pkg::pcsrc_t   mem_pcsrc,
  input  logic              mem_zero,
  input  logic              id_halt,
  input  logic              ihit,
  input  logic              dhit,
  input  logic              mem_dreq,
  output logic              pcen,
  output logic              if_id_en,
  output logic              id_ex_en,
  output logic              ex_mem_en,
  output logic              mem_wb_en,
  output logic              if_id_flush,
  output logic              id_ex_flush,
  output logic              ex_mem_flush
);
  import cpu_pkg::*;

  logic freeze, taken, load_use;

  // any outstanding miss stops every stage.
  assign freeze = !ihit || (mem_dreq && !dhit);

  always_comb begin
    case (mem_pcsrc)
      PCSRC_REG, PCSRC_JMP: taken = 1'b1;
      PCSRC_BEQ:            taken = mem_zero;
      PCSRC_BNE:            taken = !mem_zero;
      default:              taken = 1'b0;
    endcase
  end

  assign load_use = ex_dREN && (ex_rd != '0) && (ex_rd == id_rs || ex_rd == id_rt);

  // transfer beats load-use, which beats halt.
  assign pcen         = !freeze && (taken || (!load_use && !id_halt));
  assign if_id_en     = !freeze && (taken || !load_use);
  assign if_id_flush  = !freeze && (taken || (id_halt && !load_use));
  assign id_ex_en     = !freeze;
  assign id_ex_flush  = !freeze && (taken || load_use);
  assign ex_mem_en    = !freeze;
  assign ex_mem_flush = !freeze && taken;
  assign mem_wb_en    = !freeze;

endmodule

/* forwarding_unit.sv */
`timescale 1ns/100ps

module forwarding_unit (
  input  logic              ex_mem_regWEN,
  input  cpu_pkg::regbits_t ex_mem_rd,
  input  logic              mem_wb_regWEN,
  input  cpu_pkg::regbits_t mem_wb_rd,
  input  cpu_pkg::regbits_t rs,
  input  cpu_pkg::regbits_t rt,
  output cpu_pkg::fwd_t     forward_a,
  output cpu_pkg::fwd_t     forward_b
);
  import cpu_pkg::*;

  // the younger result wins; r0 is never forwarded.
  function automatic fwd_t pick(regbits_t src);
    fwd_t sel;
    if (ex_mem_regWEN && ex_mem_rd != '0 && ex_mem_rd == src) begin
      sel = FWD_EX_MEM;
    end else if (mem_wb_regWEN && mem_wb_rd != '0 && mem_wb_rd == src) begin
      sel = FWD_MEM_WB;
    end else begin
      sel = FWD_ID_EX;
    end
    return sel;
  endfunction

  always_comb begin
    forward_a = pick(rs);
    forward_b = pick(rt);
  end

endmodule

/* control_unit.sv */
`timescale 1ns/100ps

module control_unit (
  input  cpu_pkg::opcode_t opcode,
  input  cpu_pkg::funct_t  funct,
  output cpu_pkg::aluop_t  aluop,
  output cpu_pkg::alusrc_t alusrc,
  output cpu_pkg::regsrc_t regsrc,
  output cpu_pkg::regdst_t regdst,
  output cpu_pkg::pcsrc_t  pcsrc,
  output logic             extsel,
  output logic             regWEN,
  output logic             dREN,
  output logic             dWEN,
  output logic             halt_op
);
  import cpu_pkg::*;

  always_comb begin
    // defaults decode as a nop.
    aluop   = ALU_ADD;
    alusrc  = ALUSRC_REG;
    regsrc  = REGSRC_ALU;
    regdst  = REGDST_NONE;
    pcsrc   = PCSRC_NEXT;
    extsel  = 1'b0;
    regWEN  = 1'b0;
    dREN    = 1'b0;
    dWEN    = 1'b0;
    halt_op = 1'b0;
    case (opcode)
      RTYPE: begin
        regdst = REGDST_RD;
        regWEN = 1'b1;
        case (funct)
          ADDU:    aluop = ALU_ADD;
          SUBU:    aluop = ALU_SUB;
          AND:     aluop = ALU_AND;
          OR:      aluop = ALU_OR;
          SLT:     aluop = ALU_SLT;
          JR: begin
            pcsrc  = PCSRC_REG;
            regdst = REGDST_NONE;
            regWEN = 1'b0;
          end
          default: regWEN = 1'b0;
        endcase
      end
      ADDIU, LW, SW: begin
        alusrc = ALUSRC_IMM;
        extsel = 1'b1;
        regdst = (opcode == SW) ? REGDST_NONE : REGDST_RT;
        regWEN = (opcode != SW);
        regsrc = (opcode == LW) ? REGSRC_MEM : REGSRC_ALU;
        dREN   = (opcode == LW);
        dWEN   = (opcode == SW);
      end
      ORI: begin
        aluop  = ALU_OR;
        alusrc = ALUSRC_IMM;
        regdst = REGDST_RT;
        regWEN = 1'b1;
      end
      LUI: begin
        regsrc = REGSRC_LUI;
        regdst = REGDST_RT;
        regWEN = 1'b1;
      end
      // branches compare with a subtract.
      BEQ, BNE: begin
        aluop  = ALU_SUB;
        extsel = 1'b1;
        pcsrc  = (opcode == BEQ) ? PCSRC_BEQ : PCSRC_BNE;
      end
      J:    pcsrc = PCSRC_JMP;
      JAL: begin
        pcsrc  = PCSRC_JMP;
        regsrc = REGSRC_PC4;
        regdst = REGDST_RA;
        regWEN = 1'b1;
      end
      HALT: halt_op = 1'b1;
      default: ;
    endcase
  end

endmodule

/* register_file.sv */
`timescale 1ns/100ps

module register_file (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              WEN,
  input  cpu_pkg::regbits_t wsel,
  input  cpu_pkg::regbits_t rsel1,
  input  cpu_pkg::regbits_t rsel2,
  input  cpu_pkg::word_t    wdat,
  output cpu_pkg::word_t    rdat1,
  output cpu_pkg::word_t    rdat2
);
  import cpu_pkg::*;

  // r0 has no storage.
  word_t regs [1:31];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (WEN && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // same-cycle write shows up on the read port.
  function automatic word_t read_port(regbits_t sel);
    word_t val;
    if (sel == '0) begin
      val = '0;
    end else if (WEN && sel == wsel) begin
      val = wdat;
    end else begin
      val = regs[sel];
    end
    return val;
  endfunction

  always_comb begin
    rdat1 = read_port(rsel1);
    rdat2 = read_port(rsel2);
  end

endmodule

/* alu.sv */
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::aluop_t aluop,
  input  cpu_pkg::word_t  port_a,
  input  cpu_pkg::word_t  port_b,
  output cpu_pkg::word_t  port_o,
  output logic            zero
);
  import cpu_pkg::*;

  always_comb begin
    case (aluop)
      ALU_ADD: port_o = port_a + port_b;
      ALU_SUB: port_o = port_a - port_b;
      ALU_AND: port_o = port_a & port_b;
      ALU_OR:  port_o = port_a | port_b;
      // signed compare.
      ALU_SLT: port_o = {31'b0, $signed(port_a) < $signed(port_b)};
      default: port_o = port_a + port_b;
    endcase
  end

  // beq and bne look at this after a subtract.
  assign zero = (port_o == '0);

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

  // basic widths.
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // reset pc and the link register.
  localparam word_t    PC_INIT = 32'h0000_0000;
  localparam regbits_t REG_RA  = 5'd31;

  // primary opcodes.
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // function codes for rtype.
  typedef enum logic [5:0] {
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  // register format.
  typedef struct packed {
    opcode_t    opcode;
    regbits_t   rs;
    regbits_t   rt;
    regbits_t   rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_t;

  // immediate format.
  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm16;
  } i_t;

  // jump format.
  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr26;
  } j_t;

  // one instruction word, three ways to read it.
  typedef union packed {
    r_t r;
    i_t i;
    j_t j;
  } instr_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } aluop_t;

  // alu port b source.
  typedef enum logic {
    ALUSRC_REG = 1'b0,
    ALUSRC_IMM = 1'b1
  } alusrc_t;

  // write-back data source.
  typedef enum logic [1:0] {
    REGSRC_ALU = 2'd0,
    REGSRC_MEM = 2'd1,
    REGSRC_LUI = 2'd2,
    REGSRC_PC4 = 2'd3
  } regsrc_t;

  // destination register select.
  typedef enum logic [1:0] {
    REGDST_RD   = 2'd0,
    REGDST_RT   = 2'd1,
    REGDST_RA   = 2'd2,
    REGDST_NONE = 2'd3
  } regdst_t;

  // next pc select, resolved in mem.
  typedef enum logic [2:0] {
    PCSRC_NEXT = 3'd0,
    PCSRC_REG  = 3'd1,
    PCSRC_JMP  = 3'd2,
    PCSRC_BEQ  = 3'd3,
    PCSRC_BNE  = 3'd4
  } pcsrc_t;

  // operand forwarding source.
  typedef enum logic [1:0] {
    FWD_ID_EX  = 2'b00,
    FWD_MEM_WB = 2'b01,
    FWD_EX_MEM = 2'b10
  } fwd_t;

endpackage
